//--- cluster_defines.svh
`ifndef CLUSTER_DEFINES_SVH
`define CLUSTER_DEFINES_SVH

// ========================================
// Cluster dimensions
// ========================================

// Width of one data word in bits, a multiple of 16 so MOVLO has a clean low half
`define CL_XLEN 32

// Number of architectural registers, register 0 is hard-wired to zero
`define CL_NREGS 32

// Number of issue lanes, each lane owns one register file write port
`define CL_LANES 2

// Read ports of the register file, lane n reads through ports 2n and 2n+1
`define CL_RPORTS 4

`endif

//--- rf_pkg.sv
`include "cluster_defines.svh"

// ========================================
// Register file types
// ========================================

package rf_pkg;

	// Register number wide enough to name every register
	typedef logic [$clog2(`CL_NREGS)-1:0] regno_t;

	// One data word as held in the register file and carried between stages
	typedef logic [`CL_XLEN-1:0] word_t;

	// One enable bit per byte of a data word
	// Bit b covers word bits 8b+7 down to 8b
	typedef logic [`CL_XLEN/8-1:0] bytesel_t;

endpackage

//--- isa_pkg.sv
// ========================================
// Instruction set encoding
// ========================================

package isa_pkg;

	// Four-bit major opcode in the top nibble of every instruction word
	// Codes 9 to 15 are unassigned and decode as NOP
	typedef enum logic [3:0] {
		NOP   = 4'h0,
		ADD   = 4'h1,
		SUB   = 4'h2,
		AND   = 4'h3,
		OR    = 4'h4,
		XOR   = 4'h5,
		SLL   = 4'h6,
		ADDI  = 4'h7,
		MOVLO = 4'h8
	} opcode_t;

	// Register format with three register fields
	// The low 13 bits carry no information
	typedef struct packed {
		opcode_t        op;
		rf_pkg::regno_t rd;
		rf_pkg::regno_t rs1;
		rf_pkg::regno_t rs2;
		logic [12:0]    spare;
	} insn_r_t;

	// Immediate format, the immediate takes the place of rs2 and the spare bits
	typedef struct packed {
		opcode_t        op;
		rf_pkg::regno_t rd;
		rf_pkg::regno_t rs1;
		logic [17:0]    imm;
	} insn_i_t;

	// One instruction word seen through either format
	// The opcode, rd and rs1 fields sit at the same bits in both views
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_u;

endpackage

//--- insn_decode.sv
`include "cluster_defines.svh"

module insn_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid [`CL_LANES],
	input  isa_pkg::insn_u      in_instr [`CL_LANES],
	output logic                dec_valid [`CL_LANES],
	output isa_pkg::opcode_t    dec_op [`CL_LANES],
	output rf_pkg::regno_t      dec_rd [`CL_LANES],
	output rf_pkg::regno_t      dec_rs1 [`CL_LANES],
	output rf_pkg::regno_t      dec_rs2 [`CL_LANES],
	output rf_pkg::word_t       dec_imm [`CL_LANES],
	output logic                dec_use_imm [`CL_LANES]
);
	import isa_pkg::*;
	import rf_pkg::*;

	// Width of the I-format immediate and the fill needed to reach a full word
	localparam int IMM_W = 18;
	localparam int IMM_PAD = `CL_XLEN - IMM_W;

	opcode_t nxt_op [`CL_LANES];
	regno_t  nxt_rd [`CL_LANES];
	regno_t  nxt_rs1 [`CL_LANES];
	regno_t  nxt_rs2 [`CL_LANES];
	word_t   nxt_imm [`CL_LANES];
	logic    nxt_use_imm [`CL_LANES];

	// ========================================
	// Field extraction per lane
	// ========================================

	always_comb begin
		for (int l = 0; l < `CL_LANES; l++) begin
			// Unused fields read register 0, which costs nothing downstream
			nxt_op[l] = NOP;
			nxt_rd[l] = '0;
			nxt_rs1[l] = '0;
			nxt_rs2[l] = '0;
			nxt_imm[l] = '0;
			nxt_use_imm[l] = 1'b0;
			case (in_instr[l].r.op)
				ADD, SUB, AND, OR, XOR, SLL: begin
					nxt_op[l] = in_instr[l].r.op;
					nxt_rd[l] = in_instr[l].r.rd;
					nxt_rs1[l] = in_instr[l].r.rs1;
					nxt_rs2[l] = in_instr[l].r.rs2;
				end
				ADDI: begin
					// Signed immediate so small negative constants fit
					nxt_op[l] = ADDI;
					nxt_rd[l] = in_instr[l].i.rd;
					nxt_rs1[l] = in_instr[l].i.rs1;
					nxt_imm[l] = {{IMM_PAD{in_instr[l].i.imm[IMM_W-1]}}, in_instr[l].i.imm};
					nxt_use_imm[l] = 1'b1;
				end
				MOVLO: begin
					// The rs1 field is ignored, no source register is read
					nxt_op[l] = MOVLO;
					nxt_rd[l] = in_instr[l].i.rd;
					nxt_imm[l] = {{IMM_PAD{1'b0}}, in_instr[l].i.imm};
					nxt_use_imm[l] = 1'b1;
				end
				default: begin
					// Unassigned codes stay NOP and are dropped in execute
				end
			endcase
		end
	end

	// ========================================
	// Decode register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < `CL_LANES; l++) begin
				dec_valid[l] <= 1'b0;
			end
		end else begin
			for (int l = 0; l < `CL_LANES; l++) begin
				dec_valid[l] <= in_valid[l];
			end
		end
	end

	// Payload only matters while the matching valid bit is set
	always_ff @(posedge clk) begin
		for (int l = 0; l < `CL_LANES; l++) begin
			dec_op[l] <= nxt_op[l];
			dec_rd[l] <= nxt_rd[l];
			dec_rs1[l] <= nxt_rs1[l];
			dec_rs2[l] <= nxt_rs2[l];
			dec_imm[l] <= nxt_imm[l];
			dec_use_imm[l] <= nxt_use_imm[l];
		end
	end

endmodule

//--- regfile_lvt.sv
`include "cluster_defines.svh"

module regfile_lvt (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en [`CL_LANES],
	input  rf_pkg::regno_t   wr_addr [`CL_LANES],
	input  rf_pkg::bytesel_t wr_be [`CL_LANES],
	input  rf_pkg::word_t    wr_data [`CL_LANES],
	input  rf_pkg::regno_t   rd_addr [`CL_RPORTS],
	output rf_pkg::word_t    rd_data [`CL_RPORTS]
);
	import rf_pkg::*;

	localparam int LVT_W = (`CL_LANES > 1) ? $clog2(`CL_LANES) : 1;
	localparam int NBYTES = `CL_XLEN / 8;

	// Live value table, the write port that last wrote each register
	logic [LVT_W-1:0] lvt [`CL_NREGS];
	// Set once a register has been written since reset, unwritten ones read zero
	logic [`CL_NREGS-1:0] live;

	// Bank outputs at the read addresses, indexed by write port then read port
	word_t bank_rd [`CL_LANES][`CL_RPORTS];
	// Copy 0 of each bank read at every write address, for the byte merge
	word_t bank_wr_rd [`CL_LANES][`CL_LANES];
	// Full word each write port stores, old contents with new bytes laid over
	word_t wr_merged [`CL_LANES];

	// ========================================
	// Live value table
	// ========================================

	// Later ports overwrite the entry, so on a collision the highest port wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `CL_NREGS; r++) begin
				lvt[r] <= '0;
			end
			live <= '0;
		end else begin
			for (int p = 0; p < `CL_LANES; p++) begin
				if (wr_en[p]) begin
					lvt[wr_addr[p]] <= LVT_W'(p);
					live[wr_addr[p]] <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// Storage banks
	// ========================================

	// A bank only ever sees its own port's writes, so it stores the merged
	// word and always holds the complete current value of that register
	for (genvar gw = 0; gw < `CL_LANES; gw++) begin : g_wport
		for (genvar gr = 0; gr < `CL_RPORTS; gr++) begin : g_rport
			word_t mem [`CL_NREGS];

			always_ff @(posedge clk) begin
				if (wr_en[gw]) begin
					mem[wr_addr[gw]] <= wr_merged[gw];
				end
			end

			assign bank_rd[gw][gr] = mem[rd_addr[gr]];

			// The first copy also serves the old value for partial writes
			if (gr == 0) begin : g_wside
				for (genvar gp = 0; gp < `CL_LANES; gp++) begin : g_wrd
					assign bank_wr_rd[gw][gp] = mem[wr_addr[gp]];
				end
			end
		end
	end

	// ========================================
	// Byte merge and read selection
	// ========================================

	// Lower ports to the same register are applied first, so port p's word
	// already holds everything written to that register this cycle
	always_comb begin
		for (int p = 0; p < `CL_LANES; p++) begin
			wr_merged[p] = live[wr_addr[p]] ? bank_wr_rd[lvt[wr_addr[p]]][p] : '0;
			for (int q = 0; q <= p; q++) begin
				if (wr_en[q] && wr_addr[q] == wr_addr[p]) begin
					for (int b = 0; b < NBYTES; b++) begin
						if (wr_be[q][b]) begin
							wr_merged[p][b*8 +: 8] = wr_data[q][b*8 +: 8];
						end
					end
				end
			end
		end
	end

	always_comb begin
		for (int r = 0; r < `CL_RPORTS; r++) begin
			rd_data[r] = live[rd_addr[r]] ? bank_rd[lvt[rd_addr[r]]][r] : '0;
			// Forward a write in flight, the highest matching port last
			for (int p = 0; p < `CL_LANES; p++) begin
				if (wr_en[p] && wr_addr[p] == rd_addr[r]) begin
					rd_data[r] = wr_merged[p];
				end
			end
			if (rd_addr[r] == '0) begin
				rd_data[r] = '0;
			end
		end
	end

endmodule

//--- alu_execute.sv
`include "cluster_defines.svh"

module alu_execute (
	input  logic             clk,
	input  logic             rst,
	input  logic             dec_valid [`CL_LANES],
	input  isa_pkg::opcode_t dec_op [`CL_LANES],
	input  rf_pkg::regno_t   dec_rd [`CL_LANES],
	input  rf_pkg::regno_t   dec_rs1 [`CL_LANES],
	input  rf_pkg::regno_t   dec_rs2 [`CL_LANES],
	input  rf_pkg::word_t    dec_imm [`CL_LANES],
	input  logic             dec_use_imm [`CL_LANES],
	input  rf_pkg::word_t    rd_data [`CL_RPORTS],
	output logic             ex_valid [`CL_LANES],
	output rf_pkg::regno_t   ex_rd [`CL_LANES],
	output rf_pkg::word_t    ex_value [`CL_LANES],
	output rf_pkg::bytesel_t ex_be [`CL_LANES]
);
	import isa_pkg::*;
	import rf_pkg::*;

	localparam int SH_W = $clog2(`CL_XLEN);
	localparam int HALF = `CL_XLEN / 2;
	localparam bytesel_t BE_ALL = '1;
	// Enables for the bytes of the low half word only
	localparam bytesel_t BE_LOW = bytesel_t'((1 << (`CL_XLEN / 16)) - 1);

	word_t    op_a [`CL_LANES];
	word_t    op_b [`CL_LANES];
	word_t    res [`CL_LANES];
	bytesel_t res_be [`CL_LANES];

	// ========================================
	// Operand select and ALUs
	// ========================================

	always_comb begin
		for (int l = 0; l < `CL_LANES; l++) begin
			// The register file already returns zero for register 0
			op_a[l] = rd_data[2*l];
			op_b[l] = dec_use_imm[l] ? dec_imm[l] : rd_data[2*l+1];
			res_be[l] = BE_ALL;
			case (dec_op[l])
				ADD, ADDI: res[l] = op_a[l] + op_b[l];
				SUB:       res[l] = op_a[l] - op_b[l];
				AND:       res[l] = op_a[l] & op_b[l];
				OR:        res[l] = op_a[l] | op_b[l];
				XOR:       res[l] = op_a[l] ^ op_b[l];
				SLL:       res[l] = op_a[l] << op_b[l][SH_W-1:0];
				MOVLO: begin
					// Only the low half is written, the upper bytes keep their value
					res[l] = {{HALF{1'b0}}, op_b[l][HALF-1:0]};
					res_be[l] = BE_LOW;
				end
				default:   res[l] = '0;
			endcase
		end
	end

	// ========================================
	// Execute register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < `CL_LANES; l++) begin
				ex_valid[l] <= 1'b0;
			end
		end else begin
			for (int l = 0; l < `CL_LANES; l++) begin
				ex_valid[l] <= dec_valid[l] && dec_op[l] != NOP;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < `CL_LANES; l++) begin
			ex_rd[l] <= dec_rd[l];
			ex_value[l] <= res[l];
			ex_be[l] <= res_be[l];
		end
	end

endmodule

//--- retire_stage.sv
`include "cluster_defines.svh"

module retire_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic             ex_valid [`CL_LANES],
	input  rf_pkg::regno_t   ex_rd [`CL_LANES],
	input  rf_pkg::word_t    ex_value [`CL_LANES],
	input  rf_pkg::bytesel_t ex_be [`CL_LANES],
	output logic             wr_en [`CL_LANES],
	output rf_pkg::regno_t   wr_addr [`CL_LANES],
	output rf_pkg::bytesel_t wr_be [`CL_LANES],
	output rf_pkg::word_t    wr_data [`CL_LANES],
	output logic             ret_valid [`CL_LANES],
	output rf_pkg::regno_t   ret_rd [`CL_LANES],
	output rf_pkg::word_t    ret_value [`CL_LANES],
	output rf_pkg::bytesel_t ret_be [`CL_LANES],
	output logic [31:0]      ret_count
);
	// Number of lanes retiring this cycle
	logic [$clog2(`CL_LANES+1)-1:0] n_valid;

	// ========================================
	// Write ports
	// ========================================

	// Writes to register 0 are dropped here, the instruction still retires
	always_comb begin
		n_valid = '0;
		for (int l = 0; l < `CL_LANES; l++) begin
			wr_en[l] = ex_valid[l] && ex_rd[l] != '0;
			wr_addr[l] = ex_rd[l];
			wr_be[l] = ex_be[l];
			wr_data[l] = ex_value[l];
			n_valid = n_valid + ex_valid[l];
		end
	end

	// ========================================
	// Retire report
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < `CL_LANES; l++) begin
				ret_valid[l] <= 1'b0;
			end
			ret_count <= '0;
		end else begin
			for (int l = 0; l < `CL_LANES; l++) begin
				ret_valid[l] <= ex_valid[l];
			end
			ret_count <= ret_count + 32'(n_valid);
		end
	end

	// A discarded write reports zero value and no written bytes
	always_ff @(posedge clk) begin
		for (int l = 0; l < `CL_LANES; l++) begin
			ret_rd[l] <= ex_rd[l];
			ret_value[l] <= wr_en[l] ? ex_value[l] : '0;
			ret_be[l] <= wr_en[l] ? ex_be[l] : '0;
		end
	end

endmodule

//--- exec_cluster.sv
`include "cluster_defines.svh"

module exec_cluster (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid [`CL_LANES],
	input  isa_pkg::insn_u   in_instr [`CL_LANES],
	output logic             ret_valid [`CL_LANES],
	output rf_pkg::regno_t   ret_rd [`CL_LANES],
	output rf_pkg::word_t    ret_value [`CL_LANES],
	output rf_pkg::bytesel_t ret_be [`CL_LANES],
	output logic [31:0]      ret_count
);
	import isa_pkg::*;
	import rf_pkg::*;

	// Decode stage outputs
	logic     dec_valid [`CL_LANES];
	opcode_t  dec_op [`CL_LANES];
	regno_t   dec_rd [`CL_LANES];
	regno_t   dec_rs1 [`CL_LANES];
	regno_t   dec_rs2 [`CL_LANES];
	word_t    dec_imm [`CL_LANES];
	logic     dec_use_imm [`CL_LANES];

	// Register file read side
	regno_t   rd_addr [`CL_RPORTS];
	word_t    rd_data [`CL_RPORTS];

	// Execute stage outputs
	logic     ex_valid [`CL_LANES];
	regno_t   ex_rd [`CL_LANES];
	word_t    ex_value [`CL_LANES];
	bytesel_t ex_be [`CL_LANES];

	// Write ports from retire back into the register file
	logic     wr_en [`CL_LANES];
	regno_t   wr_addr [`CL_LANES];
	bytesel_t wr_be [`CL_LANES];
	word_t    wr_data [`CL_LANES];

	// ========================================
	// Stage instances
	// ========================================

	insn_decode u_decode (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm),
		.dec_use_imm(dec_use_imm)
	);

	// Lane n reads rs1 on port 2n and rs2 on port 2n+1
	for (genvar gl = 0; gl < `CL_LANES; gl++) begin : g_rdport
		assign rd_addr[2*gl] = dec_rs1[gl];
		assign rd_addr[2*gl+1] = dec_rs2[gl];
	end

	regfile_lvt u_regfile (
		.clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_be(wr_be),
		.wr_data(wr_data), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	alu_execute u_execute (
		.clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm),
		.dec_use_imm(dec_use_imm), .rd_data(rd_data), .ex_valid(ex_valid),
		.ex_rd(ex_rd), .ex_value(ex_value), .ex_be(ex_be)
	);

	retire_stage u_retire (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_rd(ex_rd),
		.ex_value(ex_value), .ex_be(ex_be), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_be(wr_be), .wr_data(wr_data), .ret_valid(ret_valid), .ret_rd(ret_rd),
		.ret_value(ret_value), .ret_be(ret_be), .ret_count(ret_count)
	);

endmodule

//--- exec_cluster_checker.sv
`include "cluster_defines.svh"

module exec_cluster_checker (
	input logic             clk,
	input logic             rst,
	input logic             ret_valid [`CL_LANES],
	input rf_pkg::regno_t   ret_rd [`CL_LANES],
	input rf_pkg::bytesel_t ret_be [`CL_LANES],
	input logic [31:0]      ret_count
);
	// Number of lanes reporting a retired instruction this cycle
	logic [31:0] n_ret;

	always_comb begin
		n_ret = '0;
		for (int l = 0; l < `CL_LANES; l++) begin
			n_ret = n_ret + 32'(ret_valid[l]);
		end
	end

	// ========================================
	// Retire report rules
	// ========================================

	// The retire registers come out of reset empty
	a_quiet_after_reset: assert property (@(posedge clk) rst |=> n_ret == '0)
		else $error("retire reported in the cycle after reset");

	// The counter and the valid bits are loaded at the same edge
	a_count_step: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> ret_count == $past(ret_count) + n_ret)
		else $error("ret_count did not grow by the number of retiring lanes");

	// A write to register 0 is dropped, so it never shows written bytes
	for (genvar gl = 0; gl < `CL_LANES; gl++) begin : g_lane
		a_no_bytes_r0: assert property (@(posedge clk) disable iff (rst)
			ret_rd[gl] == '0 |-> ret_be[gl] == '0)
			else $error("lane %0d reports written bytes for register 0", gl);
	end

endmodule

bind exec_cluster exec_cluster_checker u_checker (
	.clk(clk), .rst(rst), .ret_valid(ret_valid), .ret_rd(ret_rd),
	.ret_be(ret_be), .ret_count(ret_count)
);

//--- tb_exec_cluster.sv
`include "cluster_defines.svh"

module tb_exec_cluster;
	import isa_pkg::*;
	import rf_pkg::*;

	localparam int RAND_PAIRS = 48;
	localparam int DRAIN_LIMIT = 20;

	// One stimulus row holds an instruction pair with a valid bit per lane
	typedef struct packed {
		logic [`CL_LANES-1:0]  v;
		insn_u [`CL_LANES-1:0] w;
	} row_t;

	// Expected retire record and the cycle count at which it is sampled
	typedef struct packed {
		logic [31:0]              due;
		logic [`CL_LANES-1:0]     valid;
		regno_t [`CL_LANES-1:0]   rd;
		word_t [`CL_LANES-1:0]    value;
		bytesel_t [`CL_LANES-1:0] be;
	} exp_t;

	logic        clk;
	logic        rst;
	logic        in_valid [`CL_LANES];
	insn_u       in_instr [`CL_LANES];
	logic        ret_valid [`CL_LANES];
	regno_t      ret_rd [`CL_LANES];
	word_t       ret_value [`CL_LANES];
	bytesel_t    ret_be [`CL_LANES];
	logic [31:0] ret_count;

	row_t        stim [$];
	exp_t        pending [$];
	// Reference copy of the architectural registers
	word_t       model_regs [`CL_NREGS];
	logic [31:0] lfsr = 32'hbb4d;
	logic [31:0] cycle;
	logic [31:0] issued;
	bit          fail_shown;
	bit          passed;

	exec_cluster UUT (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
		.ret_valid(ret_valid), .ret_rd(ret_rd), .ret_value(ret_value),
		.ret_be(ret_be), .ret_count(ret_count)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic insn_u r_fmt(input opcode_t op, input int rd, input int rs1, input int rs2);
		insn_u w;
		w = '0;
		w.r.op = op;
		w.r.rd = regno_t'(rd);
		w.r.rs1 = regno_t'(rs1);
		w.r.rs2 = regno_t'(rs2);
		return w;
	endfunction

	function automatic insn_u i_fmt(input opcode_t op, input int rd, input int rs1, input int imm);
		insn_u w;
		w.i.op = op;
		w.i.rd = regno_t'(rd);
		w.i.rs1 = regno_t'(rs1);
		w.i.imm = 18'(imm);
		return w;
	endfunction

	// Random words use registers 0 to 7 as destinations so results feed each other
	function automatic insn_u rand_word();
		insn_u w;
		w.r.op = opcode_t'(4'(take_bits(4)));
		w.r.rd = regno_t'(take_bits(3));
		w.r.rs1 = regno_t'(take_bits(3));
		w.i.imm = 18'(take_bits(18));
		return w;
	endfunction

	task automatic add_row(input int v0, input insn_u w0, input int v1, input insn_u w1);
		row_t r;
		r.v[0] = (v0 != 0);
		r.v[1] = (v1 != 0);
		r.w[0] = w0;
		r.w[1] = w1;
		stim.push_back(r);
	endtask

	task automatic build_table();
		insn_u w0;
		insn_u w1;
		int v0;
		int v1;
		// Every ALU operation, negative immediates and dependent pairs
		add_row(1, i_fmt(ADDI, 1, 0, 100), 1, i_fmt(ADDI, 2, 0, -7));
		add_row(1, r_fmt(ADD, 3, 1, 2), 1, r_fmt(SUB, 4, 1, 2));
		add_row(1, r_fmt(AND, 5, 3, 4), 1, r_fmt(OR, 6, 3, 4));
		add_row(1, r_fmt(XOR, 7, 5, 6), 1, r_fmt(SLL, 8, 1, 2));
		// Lane 1 reads r9 before lane 0 of the same pair has written it
		add_row(1, i_fmt(ADDI, 9, 8, -1), 1, i_fmt(ADDI, 10, 9, 5));
		add_row(1, i_fmt(ADDI, 11, 10, 1), 1, r_fmt(ADD, 12, 9, 11));
		// MOVLO over all ones keeps the upper half and ignores its rs1 field
		add_row(1, i_fmt(ADDI, 13, 0, -1), 1, r_fmt(NOP, 1, 2, 3));
		add_row(1, i_fmt(MOVLO, 13, 5, 'h3abcd), 0, i_fmt(ADDI, 23, 1, 9));
		add_row(1, r_fmt(ADD, 14, 13, 0), 1, r_fmt(ADD, 24, 0, 23));
		// Both lanes hit one register and lane 1 must win
		add_row(1, i_fmt(ADDI, 15, 0, 11), 1, i_fmt(ADDI, 15, 0, 22));
		add_row(1, r_fmt(ADD, 16, 15, 0), 1, r_fmt(ADD, 17, 0, 15));
		add_row(1, i_fmt(ADDI, 18, 0, -2), 1, i_fmt(MOVLO, 18, 0, 'h5555));
		// Register 0 as destination, then as source, then an unassigned opcode
		add_row(1, r_fmt(ADD, 19, 18, 0), 1, i_fmt(ADDI, 0, 1, 5));
		add_row(1, r_fmt(ADD, 20, 0, 0), 1, insn_u'(32'hf1234567));
		// By now r15 comes from the bank that the live value table names
		add_row(1, r_fmt(OR, 21, 0, 15), 1, r_fmt(ADD, 22, 20, 0));
		for (int i = 0; i < RAND_PAIRS; i++) begin
			v0 = int'(take_bits(1));
			w0 = rand_word();
			v1 = int'(take_bits(1));
			w1 = rand_word();
			add_row(v0, w0, v1, w1);
		end
	endtask

	// ========================================
	// Reference model and checking
	// ========================================

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_shown = 1'b1;
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Both lanes read the registers as they were before the pair, then
	// lane 0 writes and lane 1 writes over it byte by byte
	task automatic run_model(input row_t r, output exp_t e);
		word_t    a;
		word_t    b;
		word_t    imm_s;
		word_t    res [`CL_LANES];
		bytesel_t be [`CL_LANES];
		logic     ok [`CL_LANES];
		regno_t   rd;
		for (int l = 0; l < `CL_LANES; l++) begin
			a = model_regs[r.w[l].r.rs1];
			b = model_regs[r.w[l].r.rs2];
			imm_s = {{14{r.w[l].i.imm[17]}}, r.w[l].i.imm};
			res[l] = '0;
			be[l] = 4'b1111;
			ok[l] = r.v[l];
			case (r.w[l].r.op)
				ADD:     res[l] = a + b;
				SUB:     res[l] = a - b;
				AND:     res[l] = a & b;
				OR:      res[l] = a | b;
				XOR:     res[l] = a ^ b;
				SLL:     res[l] = a << b[4:0];
				ADDI:    res[l] = a + imm_s;
				MOVLO: begin
					res[l] = {16'h0000, r.w[l].i.imm[15:0]};
					be[l] = 4'b0011;
				end
				default: ok[l] = 1'b0;
			endcase
		end
		for (int l = 0; l < `CL_LANES; l++) begin
			rd = r.w[l].r.rd;
			e.valid[l] = ok[l];
			e.rd[l] = rd;
			e.value[l] = '0;
			e.be[l] = '0;
			if (ok[l] && rd != '0) begin
				e.value[l] = res[l];
				e.be[l] = be[l];
				for (int k = 0; k < 4; k++) begin
					if (be[l][k]) begin
						model_regs[rd][k*8 +: 8] = res[l][k*8 +: 8];
					end
				end
			end
		end
		// Sampled on the third falling edge after the one that drives the pair
		e.due = cycle + 3;
	endtask

	task automatic check_due();
		exp_t e;
		while (pending.size() != 0 && pending[0].due == cycle) begin
			e = pending.pop_front();
			for (int l = 0; l < `CL_LANES; l++) begin
				compare($sformatf("ret_valid[%0d]", l), 32'(ret_valid[l]), 32'(e.valid[l]));
				if (e.valid[l]) begin
					compare($sformatf("ret_rd[%0d]", l), 32'(ret_rd[l]), 32'(e.rd[l]));
					compare($sformatf("ret_value[%0d]", l), ret_value[l], e.value[l]);
					compare($sformatf("ret_be[%0d]", l), 32'(ret_be[l]), 32'(e.be[l]));
				end
			end
		end
	endtask

	task automatic drive_row(input row_t r);
		exp_t e;
		@(negedge clk);
		cycle = cycle + 1;
		check_due();
		for (int l = 0; l < `CL_LANES; l++) begin
			in_valid[l] = r.v[l];
			in_instr[l] = r.w[l];
		end
		run_model(r, e);
		pending.push_back(e);
		for (int l = 0; l < `CL_LANES; l++) begin
			issued = issued + 32'(e.valid[l]);
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int waited;
		rst = 1'b1;
		for (int l = 0; l < `CL_LANES; l++) begin
			in_valid[l] = 1'b0;
			in_instr[l] = '0;
		end
		for (int r = 0; r < `CL_NREGS; r++) begin
			model_regs[r] = '0;
		end
		cycle = '0;
		issued = '0;
		fail_shown = 1'b0;
		passed = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (stim[i]) begin
			drive_row(stim[i]);
		end
		@(negedge clk);
		cycle = cycle + 1;
		check_due();
		for (int l = 0; l < `CL_LANES; l++) begin
			in_valid[l] = 1'b0;
		end
		// Let the last pairs leave the pipeline
		waited = 0;
		while (pending.size() != 0) begin
			if (waited == DRAIN_LIMIT) begin
				$display("timeout: retire records still outstanding after the drain limit");
				fail_shown = 1'b1;
				$display("Test failed");
				$fatal(1, "drain timeout");
			end
			@(negedge clk);
			cycle = cycle + 1;
			check_due();
			waited++;
		end
		compare("ret_count", ret_count, issued);
		passed = 1'b1;
		$display("Test passed");
		$finish;
	end

	final begin
		if (!passed && !fail_shown) begin
			$display("Test failed");
		end
	end

endmodule

//--- project.f
+incdir+.
rf_pkg.sv
isa_pkg.sv
insn_decode.sv
regfile_lvt.sv
alu_execute.sv
retire_stage.sv
exec_cluster.sv
exec_cluster_checker.sv
tb_exec_cluster.sv

//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -Wno-fatal
TOP      = tb_exec_cluster
FILELIST = project.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "Test passed"; then \
		echo "PASS"; \
	else \
		echo "FAIL: no pass report in simulation output"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD)
